//--- rtl/cnn_cfg_pkg.sv
package cnn_cfg_pkg;

    // Numeric formats
    localparam int ACT_W   = 8;   // Unsigned activation
    localparam int WGT_W   = 8;   // Signed kernel weight
    localparam int BIAS_W  = 16;  // Signed bias
    localparam int SHIFT_W = 4;
    localparam int ACC_W   = 24;  // Signed accumulator

    // Weight port address map
    localparam int ADDR_W    = 12;
    localparam int LAYER_MSB = 11;
    localparam int LAYER_LSB = 10;
    localparam int KIND_MSB  = 9;
    localparam int KIND_LSB  = 8;
    localparam int IDX_MSB   = 7;
    localparam int IDX_LSB   = 0;

    // Field widths of a decoded write
    localparam int LAYER_W = LAYER_MSB - LAYER_LSB + 1;
    localparam int IDX_W   = IDX_MSB - IDX_LSB + 1;
    localparam int WDATA_W = 16;

    // Code 3 is reserved and answered with an error
    typedef enum logic [1:0] {
        WK_KERNEL = 2'd0,
        WK_BIAS   = 2'd1,
        WK_SHIFT  = 2'd2
    } wkind_e;

endpackage

//--- rtl/cnn_types_pkg.sv
package cnn_types_pkg;

    import cnn_cfg_pkg::*;

    // One decoded weight write, broadcast to all layers
    typedef struct packed {
        logic               valid;
        logic [LAYER_W-1:0] layer;
        wkind_e             kind;
        logic [IDX_W-1:0]   index;  // Kernel: out_ch * IN_CH + in_ch
        logic [WDATA_W-1:0] data;
    } wt_wr_t;

    typedef logic [ACT_W-1:0] act_t;

endpackage

//--- rtl/weight_apb_decode.sv
module weight_apb_decode #(
    parameter int L0_IN_CH  = 3,
    parameter int L0_OUT_CH = 4,
    parameter int L1_OUT_CH = 2
) (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_psel,
    input  logic                           i_penable,
    input  logic                           i_pwrite,
    input  logic [cnn_cfg_pkg::ADDR_W-1:0] i_paddr,
    input  logic [31:0]                    i_pwdata,
    output logic                           o_pready,
    output logic                           o_pslverr,
    output cnn_types_pkg::wt_wr_t          o_wt_wr
);

    import cnn_cfg_pkg::*;

    logic               setup;
    logic               access;
    logic [LAYER_W-1:0] a_layer;
    logic [1:0]         a_kind;
    logic [IDX_W-1:0]   a_idx;
    int                 lay_in;
    int                 lay_out;
    int                 idx_lim;
    logic               addr_ok;

    logic               err_q;
    logic [LAYER_W-1:0] layer_q;
    wkind_e             kind_q;
    logic [IDX_W-1:0]   idx_q;
    logic [WDATA_W-1:0] data_q;

    assign setup  = i_psel & ~i_penable;
    assign access = i_psel & i_penable;

    assign a_layer = i_paddr[LAYER_MSB:LAYER_LSB];
    assign a_kind  = i_paddr[KIND_MSB:KIND_LSB];
    assign a_idx   = i_paddr[IDX_MSB:IDX_LSB];

    // Legal index count per layer and kind, zero for unmapped space
    always_comb begin
        case (a_layer)
            2'd0: begin
                lay_in  = L0_IN_CH;
                lay_out = L0_OUT_CH;
            end
            2'd1: begin
                lay_in  = L0_OUT_CH;
                lay_out = L1_OUT_CH;
            end
            default: begin
                lay_in  = 0;
                lay_out = 0;
            end
        endcase
        case (a_kind)
            WK_KERNEL: idx_lim = lay_in * lay_out;
            WK_BIAS:   idx_lim = lay_out;
            WK_SHIFT:  idx_lim = (lay_out > 0) ? 1 : 0;
            default:   idx_lim = 0;
        endcase
    end

    assign addr_ok = int'(a_idx) < idx_lim;

    // Decision taken in the setup phase, answered in the access phase
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            err_q <= 1'b0;
        end else if (setup) begin
            err_q <= ~i_pwrite | ~addr_ok;  // Reads are not supported
        end
    end

    always_ff @(posedge i_clk) begin
        if (setup) begin
            layer_q <= a_layer;
            kind_q  <= wkind_e'(a_kind);
            idx_q   <= a_idx;
            data_q  <= i_pwdata[WDATA_W-1:0];
        end
    end

    assign o_pready  = access;  // No wait states
    assign o_pslverr = access & err_q;

    always_comb begin
        o_wt_wr.valid = access & ~err_q;
        o_wt_wr.layer = layer_q;
        o_wt_wr.kind  = kind_q;
        o_wt_wr.index = idx_q;
        o_wt_wr.data  = data_q;
    end

endmodule

//--- rtl/pointwise_mac.sv
module pointwise_mac #(
    parameter int IN_CH  = 3,
    parameter int OUT_CH = 4
) (
    input  logic                                             i_clk,
    input  logic                                             i_rst,
    input  logic [OUT_CH*IN_CH-1:0][cnn_cfg_pkg::WGT_W-1:0]  i_kernel,
    input  logic                                             i_valid,
    input  cnn_types_pkg::act_t [IN_CH-1:0]                  i_act,
    output logic                                             o_ready,
    output logic                                             o_valid,
    output logic [OUT_CH-1:0][cnn_cfg_pkg::ACC_W-1:0]        o_acc,
    input  logic                                             i_ready
);

    import cnn_cfg_pkg::*;

    logic [OUT_CH-1:0][ACC_W-1:0] acc_sum;
    logic [OUT_CH-1:0][ACC_W-1:0] acc_q;
    logic                         vld_q;

    always_comb begin
        logic signed [ACC_W-1:0] sum_v;
        for (int o = 0; o < OUT_CH; o++) begin
            sum_v = '0;
            for (int i = 0; i < IN_CH; i++) begin
                // Activation is unsigned, zero-extend before the signed multiply
                sum_v = sum_v + $signed({1'b0, i_act[i]}) * $signed(i_kernel[o*IN_CH+i]);
            end
            acc_sum[o] = sum_v;
        end
    end

    assign o_ready = ~vld_q | i_ready;  // Empty or draining

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            vld_q <= 1'b0;
        end else if (o_ready) begin
            vld_q <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid && o_ready) begin
            acc_q <= acc_sum;
        end
    end

    assign o_valid = vld_q;
    assign o_acc   = acc_q;

endmodule

//--- rtl/requant_relu.sv
module requant_relu #(
    parameter int OUT_CH = 4
) (
    input  logic                                      i_clk,
    input  logic                                      i_rst,
    input  logic [OUT_CH-1:0][cnn_cfg_pkg::BIAS_W-1:0] i_bias,
    input  logic [cnn_cfg_pkg::SHIFT_W-1:0]            i_shift,
    input  logic                                      i_valid,
    input  logic [OUT_CH-1:0][cnn_cfg_pkg::ACC_W-1:0]  i_acc,
    output logic                                      o_ready,
    output logic                                      o_valid,
    output cnn_types_pkg::act_t [OUT_CH-1:0]          o_act,
    input  logic                                      i_ready
);

    import cnn_cfg_pkg::*;
    import cnn_types_pkg::*;

    localparam int ACT_MAX = (1 << ACT_W) - 1;

    act_t [OUT_CH-1:0] res;
    act_t [OUT_CH-1:0] act_q;
    logic              vld_q;

    always_comb begin
        logic signed [ACC_W:0] biased;  // One guard bit for the bias add
        logic signed [ACC_W:0] scaled;
        for (int o = 0; o < OUT_CH; o++) begin
            biased = $signed(i_acc[o]) + $signed(i_bias[o]);
            scaled = biased >>> i_shift;
            if (scaled < 0) begin
                res[o] = '0;  // ReLU
            end else if (scaled > ACT_MAX) begin
                res[o] = act_t'(ACT_MAX);
            end else begin
                res[o] = scaled[ACT_W-1:0];
            end
        end
    end

    assign o_ready = ~vld_q | i_ready;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            vld_q <= 1'b0;
        end else if (o_ready) begin
            vld_q <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid && o_ready) begin
            act_q <= res;
        end
    end

    assign o_valid = vld_q;
    assign o_act   = act_q;

endmodule

//--- rtl/conv_layer.sv
module conv_layer #(
    parameter int LAYER_ID = 0,
    parameter int IN_CH    = 3,
    parameter int OUT_CH   = 4
) (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  cnn_types_pkg::wt_wr_t            i_wt_wr,
    input  logic                             i_valid,
    input  cnn_types_pkg::act_t [IN_CH-1:0]  i_act,
    output logic                             o_ready,
    output logic                             o_valid,
    output cnn_types_pkg::act_t [OUT_CH-1:0] o_act,
    input  logic                             i_ready
);

    import cnn_cfg_pkg::*;

    logic [OUT_CH*IN_CH-1:0][WGT_W-1:0] kernel;
    logic [OUT_CH-1:0][BIAS_W-1:0]      bias;
    logic [SHIFT_W-1:0]                 shift;
    logic                               hit;

    logic                               mac_valid;
    logic                               rq_ready;
    logic [OUT_CH-1:0][ACC_W-1:0]       mac_acc;

    // Layer select happens here, the decoder broadcasts
    assign hit = i_wt_wr.valid && (i_wt_wr.layer == LAYER_W'(LAYER_ID));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            kernel <= '0;
            bias   <= '0;
            shift  <= '0;
        end else if (hit) begin
            case (i_wt_wr.kind)
                WK_KERNEL: kernel[i_wt_wr.index] <= i_wt_wr.data[WGT_W-1:0];
                WK_BIAS:   bias[i_wt_wr.index] <= i_wt_wr.data[BIAS_W-1:0];
                WK_SHIFT:  shift <= i_wt_wr.data[SHIFT_W-1:0];
                default:   ;
            endcase
        end
    end

    pointwise_mac #(
        .IN_CH    (IN_CH),
        .OUT_CH   (OUT_CH)
    ) mac (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_kernel (kernel),
        .i_valid  (i_valid),
        .i_act    (i_act),
        .o_ready  (o_ready),
        .o_valid  (mac_valid),
        .o_acc    (mac_acc),
        .i_ready  (rq_ready)
    );

    requant_relu #(
        .OUT_CH   (OUT_CH)
    ) requant (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_bias   (bias),
        .i_shift  (shift),
        .i_valid  (mac_valid),
        .i_acc    (mac_acc),
        .o_ready  (rq_ready),
        .o_valid  (o_valid),
        .o_act    (o_act),
        .i_ready  (i_ready)
    );

endmodule

//--- rtl/stream_fifo.sv
module stream_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_valid,
    input  T     i_data,
    output logic o_ready,
    output logic o_valid,
    output T     o_data,
    input  logic i_ready
);

    localparam int PTR_W = $clog2(DEPTH);

    T               mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             wr_en;
    logic             rd_en;

    assign o_ready = count != (PTR_W+1)'(DEPTH);
    assign o_valid = count != '0;
    assign o_data  = mem[rd_ptr];  // Show-ahead

    assign wr_en = i_valid & o_ready;
    assign rd_en = o_valid & i_ready;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // Both or neither
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_data;
        end
    end

endmodule

//--- rtl/cnn_model.sv
module cnn_model #(
    parameter int L0_IN_CH   = 3,
    parameter int L0_OUT_CH  = 4,
    parameter int L1_OUT_CH  = 2,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                i_clk,
    input  logic                                i_rst,
    input  logic                                i_psel,
    input  logic                                i_penable,
    input  logic                                i_pwrite,
    input  logic [cnn_cfg_pkg::ADDR_W-1:0]      i_paddr,
    input  logic [31:0]                         i_pwdata,
    output logic                                o_pready,
    output logic                                o_pslverr,
    input  logic                                i_valid,
    input  cnn_types_pkg::act_t [L0_IN_CH-1:0]  i_pix,
    output logic                                o_ready,
    output logic                                o_valid,
    output cnn_types_pkg::act_t [L1_OUT_CH-1:0] o_res,
    input  logic                                i_ready
);

    import cnn_types_pkg::*;

    typedef act_t [L0_OUT_CH-1:0] l0_vec_t;
    typedef act_t [L1_OUT_CH-1:0] l1_vec_t;

    wt_wr_t  wt_wr;

    logic    l0_valid;
    logic    l0_ready;
    l0_vec_t l0_act;
    logic    f0_valid;
    logic    f0_ready;
    l0_vec_t f0_act;
    logic    l1_valid;
    logic    l1_ready;
    l1_vec_t l1_act;

    weight_apb_decode #(
        .L0_IN_CH  (L0_IN_CH),
        .L0_OUT_CH (L0_OUT_CH),
        .L1_OUT_CH (L1_OUT_CH)
    ) apb_decode (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .o_wt_wr   (wt_wr)
    );

    conv_layer #(.LAYER_ID(0), .IN_CH(L0_IN_CH), .OUT_CH(L0_OUT_CH)) layer_0 (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_wt_wr (wt_wr),
        .i_valid (i_valid),
        .i_act   (i_pix),
        .o_ready (o_ready),
        .o_valid (l0_valid),
        .o_act   (l0_act),
        .i_ready (l0_ready)
    );

    stream_fifo #(.T(l0_vec_t), .DEPTH(FIFO_DEPTH)) fifo_0 (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (l0_valid),
        .i_data  (l0_act),
        .o_ready (l0_ready),
        .o_valid (f0_valid),
        .o_data  (f0_act),
        .i_ready (f0_ready)
    );

    conv_layer #(.LAYER_ID(1), .IN_CH(L0_OUT_CH), .OUT_CH(L1_OUT_CH)) layer_1 (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_wt_wr (wt_wr),
        .i_valid (f0_valid),
        .i_act   (f0_act),
        .o_ready (f0_ready),
        .o_valid (l1_valid),
        .o_act   (l1_act),
        .i_ready (l1_ready)
    );

    stream_fifo #(.T(l1_vec_t), .DEPTH(FIFO_DEPTH)) fifo_out (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (l1_valid),
        .i_data  (l1_act),
        .o_ready (l1_ready),
        .o_valid (o_valid),
        .o_data  (o_res),
        .i_ready (i_ready)
    );

endmodule

//--- dv/cnn_model_tb.sv
module cnn_model_tb;

    import cnn_cfg_pkg::*;
    import cnn_types_pkg::*;

    localparam int NUM_ENT     = 10;
    localparam int TIMEOUT_CYC = (NUM_ENT + 8) * 40;

    typedef struct packed {
        logic [23:0] pix;      // Channel 0 in the low byte
        logic [7:0]  rdy_pat;  // Output ready bits, one per cycle
    } stim_t;

    logic                     i_clk;
    logic                     i_rst;
    logic                     i_psel;
    logic                     i_penable;
    logic                     i_pwrite;
    logic [ADDR_W-1:0]        i_paddr;
    logic [31:0]              i_pwdata;
    logic                     o_pready;
    logic                     o_pslverr;
    logic                     i_valid;
    act_t [2:0]               i_pix;
    logic                     o_ready;
    logic                     o_valid;
    act_t [1:0]               o_res;
    logic                     i_ready;

    logic [23:0] pix_tab [NUM_ENT] = '{24'h000000, 24'hffffff, 24'h0000ff, 24'h1ec80a,
                                      24'h5a05c8, 24'h204080, 24'h030201, 24'hfa00fa,
                                      24'h00ff00, 24'h64c832};
    stim_t       tab [NUM_ENT];
    integer      seed = 32'ha2c2;

    // Weights as written over APB, kernel index is out * IN_CH + in
    int k0 [12] = '{1, 1, 1, -2, 1, 0, 3, 2, 1, 1, -1, 2};
    int b0 [4]  = '{10, -20, 0, 5};
    int s0      = 1;
    int k1 [8]  = '{1, 2, -1, 1, -1, 1, 3, -2};
    int b1 [2]  = '{-50, 30};
    int s1      = 0;

    logic [15:0] exp_q [$];
    logic [15:0] exp_v;
    logic        rand_rdy;
    logic        hold_rdy;
    logic [7:0]  cur_pat;
    logic [2:0]  phase;

    cnn_model #(
        .L0_IN_CH   (3),
        .L0_OUT_CH  (4),
        .L1_OUT_CH  (2),
        .FIFO_DEPTH (4)
    ) dut0 (.*);

    always #5 i_clk = ~i_clk;

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("FAIL @%0t: %s got %0h expected %0h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    function automatic int relu_sat(input int v);
        if (v < 0) begin
            return 0;
        end else if (v > 255) begin
            return 255;
        end else begin
            return v;
        end
    endfunction

    function automatic logic [15:0] ref_result(input logic [23:0] pix);
        int          mid [4];
        int          acc;
        logic [15:0] res;
        for (int o = 0; o < 4; o++) begin
            acc = b0[o];
            for (int i = 0; i < 3; i++) begin
                acc += int'(pix[i*8 +: 8]) * k0[o*3+i];
            end
            mid[o] = relu_sat(acc >>> s0);
        end
        for (int o = 0; o < 2; o++) begin
            acc = b1[o];
            for (int i = 0; i < 4; i++) begin
                acc += mid[i] * k1[o*4+i];
            end
            res[o*8 +: 8] = 8'(relu_sat(acc >>> s1));
        end
        return res;
    endfunction

    task automatic apb_access(input logic wr, input logic [1:0] lay, input logic [1:0] kind,
                              input logic [7:0] idx, input logic [31:0] data,
                              input logic exp_err);
        @(posedge i_clk);
        i_psel    <= 1'b1;
        i_penable <= 1'b0;
        i_pwrite  <= wr;
        i_paddr   <= {lay, kind, idx};
        i_pwdata  <= data;
        @(posedge i_clk);
        i_penable <= 1'b1;
        @(negedge i_clk);
        check_eq(o_pready, 1'b1, "pready in access phase");
        check_eq(o_pslverr, exp_err, "pslverr in access phase");
        @(posedge i_clk);
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
    endtask

    task automatic load_all_weights();
        for (int n = 0; n < 12; n++) apb_access(1'b1, 2'd0, WK_KERNEL, 8'(n), k0[n], 1'b0);
        for (int n = 0; n < 4; n++) apb_access(1'b1, 2'd0, WK_BIAS, 8'(n), b0[n], 1'b0);
        apb_access(1'b1, 2'd0, WK_SHIFT, 8'd0, s0, 1'b0);
        for (int n = 0; n < 8; n++) apb_access(1'b1, 2'd1, WK_KERNEL, 8'(n), k1[n], 1'b0);
        for (int n = 0; n < 2; n++) apb_access(1'b1, 2'd1, WK_BIAS, 8'(n), b1[n], 1'b0);
        apb_access(1'b1, 2'd1, WK_SHIFT, 8'd0, s1, 1'b0);
    endtask

    // Push the table through twice, then wait until every result is back
    task automatic run_stream(input logic random_ready);
        int e;
        rand_rdy <= random_ready;
        hold_rdy <= random_ready;  // Output held off until the input backs up
        for (int k = 0; k < 2 * NUM_ENT; k++) begin
            e = k % NUM_ENT;
            cur_pat <= tab[e].rdy_pat;
            @(posedge i_clk);
            i_valid <= 1'b1;
            i_pix   <= tab[e].pix;
            @(negedge i_clk);
            while (!o_ready) begin
                hold_rdy <= 1'b0;
                @(negedge i_clk);
            end
            exp_q.push_back(ref_result(tab[e].pix));
        end
        @(posedge i_clk);
        i_valid <= 1'b0;
        while (exp_q.size() != 0) @(negedge i_clk);
    endtask

    always @(posedge i_clk) begin
        i_ready <= hold_rdy ? 1'b0 : (rand_rdy ? cur_pat[phase] : 1'b1);
        phase   <= phase + 1'b1;
    end

    always @(negedge i_clk) begin
        if (!i_rst && o_valid && i_ready) begin  // Transfer at the coming edge
            check_eq(exp_q.size() != 0, 1'b1, "output with an expected result pending");
            exp_v = exp_q.pop_front();
            check_eq(o_res, exp_v, "network result");
        end
    end

    initial begin
        repeat (TIMEOUT_CYC) @(posedge i_clk);
        $display("Simulation timed out after %0d cycles without finishing", TIMEOUT_CYC);
        $display("TEST FAILED");
        $fatal(1);
    end

    initial begin
        i_clk     = 1'b0;
        i_rst     = 1'b1;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = '0;
        i_pwdata  = '0;
        i_valid   = 1'b0;
        i_pix     = '0;
        i_ready   = 1'b0;
        rand_rdy  = 1'b0;
        hold_rdy  = 1'b0;
        cur_pat   = 8'hff;
        phase     = '0;
        for (int k = 0; k < NUM_ENT; k++) begin
            tab[k].pix     = pix_tab[k];
            tab[k].rdy_pat = 8'($random(seed)) | 8'h01;  // Never stuck low
        end
        repeat (2) @(posedge i_clk);
        i_rst <= 1'b0;
        @(negedge i_clk);
        check_eq(o_valid, 1'b0, "o_valid after reset");
        check_eq(o_pslverr, 1'b0, "o_pslverr after reset");

        load_all_weights();
        run_stream(1'b0);
        run_stream(1'b1);

        // Rejected accesses leave every weight untouched
        apb_access(1'b0, 2'd0, WK_KERNEL, 8'd0, 32'h0, 1'b1);
        apb_access(1'b1, 2'd2, WK_KERNEL, 8'd0, 32'h7f, 1'b1);
        apb_access(1'b1, 2'd0, 2'd3, 8'd0, 32'h7f, 1'b1);
        apb_access(1'b1, 2'd1, WK_KERNEL, 8'd8, 32'h7f, 1'b1);
        run_stream(1'b1);

        s1    = 1;
        b1[0] = 100;
        b1[1] = -10;
        apb_access(1'b1, 2'd1, WK_SHIFT, 8'd0, s1, 1'b0);
        apb_access(1'b1, 2'd1, WK_BIAS, 8'd0, b1[0], 1'b0);
        apb_access(1'b1, 2'd1, WK_BIAS, 8'd1, b1[1], 1'b0);
        run_stream(1'b1);

        repeat (10) @(negedge i_clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- cnn_model.f
rtl/cnn_cfg_pkg.sv
rtl/cnn_types_pkg.sv
rtl/weight_apb_decode.sv
rtl/pointwise_mac.sv
rtl/requant_relu.sv
rtl/conv_layer.sv
rtl/stream_fifo.sv
rtl/cnn_model.sv
dv/cnn_model_tb.sv

//--- Bender.yml
package:
  name: cnn_model

sources:
  - rtl/cnn_cfg_pkg.sv
  - rtl/cnn_types_pkg.sv
  - rtl/weight_apb_decode.sv
  - rtl/pointwise_mac.sv
  - rtl/requant_relu.sv
  - rtl/conv_layer.sv
  - rtl/stream_fifo.sv
  - rtl/cnn_model.sv
  - target: test
    files:
      - dv/cnn_model_tb.sv
